/* common/rv_pipe_cfg.svh */
`ifndef RV_PIPE_CFG_SVH
`define RV_PIPE_CFG_SVH

// data and address width
`define RV_XLEN 32

// architectural registers, x0 included
`define RV_REGS 32

// first fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

`endif

/* common/rv_isa_pkg.sv */
`include "rv_pipe_cfg.svh"

package rv_isa_pkg;

    typedef logic [`RV_XLEN-1:0]         word_t;     // data, address or instruction
    typedef logic [$clog2(`RV_REGS)-1:0] reg_addr_t;
    typedef logic [6:0]                  opcode_t;
    typedef logic [2:0]                  funct3_t;
    typedef logic [6:0]                  funct7_t;

    // major opcodes of the supported subset
    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LUI    = 7'b0110111;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;

    // register and immediate arithmetic
    localparam funct3_t F3_ADD = 3'b000;    // add, sub, addi
    localparam funct3_t F3_SLT = 3'b010;
    localparam funct3_t F3_XOR = 3'b100;
    localparam funct3_t F3_OR  = 3'b110;
    localparam funct3_t F3_AND = 3'b111;

    // word access, lw and sw
    localparam funct3_t F3_WORD = 3'b010;

    // conditional branches
    localparam funct3_t F3_BEQ = 3'b000;
    localparam funct3_t F3_BNE = 3'b001;

    // funct7 of sub, the only alternate encoding kept
    localparam funct7_t F7_SUB = 7'b0100000;

endpackage

/* common/rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

    typedef logic [2:0] alu_op_t;

    localparam alu_op_t ALU_ADD   = 3'd0;
    localparam alu_op_t ALU_SUB   = 3'd1;
    localparam alu_op_t ALU_AND   = 3'd2;
    localparam alu_op_t ALU_OR    = 3'd3;
    localparam alu_op_t ALU_XOR   = 3'd4;
    localparam alu_op_t ALU_SLT   = 3'd5;
    localparam alu_op_t ALU_PASSB = 3'd6;  // operand b straight through, for lui

    // one bit per source operand of the EX instruction
    typedef logic [1:0] fwd_sel_t;

    localparam int FWD_RS1 = 0;
    localparam int FWD_RS2 = 1;

endpackage

/* design/fetch_stage.sv */
`include "rv_pipe_cfg.svh"

module fetch_stage
    import rv_isa_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  hold,
    input  logic  pc_stall,
    input  logic  if_id_stall,
    input  logic  if_id_flush,
    input  logic  ex_redirect,
    input  word_t redirect_pc,
    input  word_t imem_data,
    output word_t imem_addr,
    output word_t id_pc,
    output word_t id_instr,
    output logic  id_valid
);

    word_t pc;

    assign imem_addr = pc;

    // redirect wins over a load-use stall
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc <= `RV_RESET_PC;
        end else if (!hold) begin
            if (ex_redirect)
                pc <= redirect_pc;
            else if (!pc_stall)
                pc <= pc + word_t'(4);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_valid <= 1'b0;
        end else if (!hold) begin
            if (if_id_flush)
                id_valid <= 1'b0;               // wrong-path slot
            else if (!if_id_stall)
                id_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold && !if_id_stall) begin
            id_pc    <= pc;
            id_instr <= imem_data;
        end
    end

endmodule

/* design/decode_stage.sv */
`include "rv_pipe_cfg.svh"

module decode_stage
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      hold,
    input  word_t     id_pc,
    input  word_t     id_instr,
    input  logic      id_valid,
    input  logic      id_ex_flush,
    input  reg_addr_t wb_rd,
    input  logic      wb_reg_we,
    input  word_t     wb_data,
    output reg_addr_t id_rs1,
    output reg_addr_t id_rs2,
    output word_t     ex_pc,
    output word_t     ex_rs1_data,
    output word_t     ex_rs2_data,
    output word_t     ex_imm,
    output reg_addr_t ex_rd,
    output reg_addr_t ex_rs1,
    output reg_addr_t ex_rs2,
    output alu_op_t   ex_alu_op,
    output logic      ex_alu_src_imm,
    output logic      ex_is_load,
    output logic      ex_is_store,
    output logic      ex_is_branch,
    output logic      ex_branch_ne,
    output logic      ex_is_jal,
    output logic      ex_reg_we
);

    opcode_t   opcode;
    funct3_t   funct3;
    logic      alt;
    word_t     imm_i, imm_s, imm_b, imm_u, imm_j, imm;
    alu_op_t   alu_op;
    logic      src_imm, is_load, is_store, is_branch, branch_ne, is_jal, reg_we;
    logic      use_rs1, use_rs2;
    word_t     regs [`RV_REGS];
    word_t     rs1_data, rs2_data;

    // funct3 to ALU function; alt only set for register-register ops
    function automatic alu_op_t alu_from_f3(funct3_t f3, logic sub);
        case (f3)
            F3_ADD:  return sub ? ALU_SUB : ALU_ADD;
            F3_SLT:  return ALU_SLT;
            F3_XOR:  return ALU_XOR;
            F3_OR:   return ALU_OR;
            F3_AND:  return ALU_AND;
            default: return ALU_ADD;
        endcase
    endfunction

    assign opcode = id_instr[6:0];
    assign funct3 = id_instr[14:12];
    assign alt    = (id_instr[31:25] == F7_SUB);

    assign imm_i = {{20{id_instr[31]}}, id_instr[31:20]};
    assign imm_s = {{20{id_instr[31]}}, id_instr[31:25], id_instr[11:7]};
    assign imm_b = {{19{id_instr[31]}}, id_instr[31], id_instr[7], id_instr[30:25],
                    id_instr[11:8], 1'b0};
    assign imm_u = {id_instr[31:12], 12'b0};
    assign imm_j = {{11{id_instr[31]}}, id_instr[31], id_instr[19:12], id_instr[20],
                    id_instr[30:21], 1'b0};

    always_comb begin
        {src_imm, is_load, is_store, is_branch, branch_ne, is_jal, reg_we} = '0;
        {use_rs1, use_rs2} = '0;
        alu_op = ALU_ADD;
        imm    = imm_i;
        if (id_valid) begin
            case (opcode)
                OP_REG: begin
                    {use_rs1, use_rs2, reg_we} = '1;
                    alu_op = alu_from_f3(funct3, alt);
                end
                OP_IMM: begin
                    {use_rs1, reg_we, src_imm} = '1;
                    alu_op = alu_from_f3(funct3, 1'b0);
                end
                OP_LUI: begin
                    {reg_we, src_imm} = '1;
                    alu_op = ALU_PASSB;
                    imm    = imm_u;
                end
                OP_LOAD: if (funct3 == F3_WORD) begin
                    {use_rs1, is_load, reg_we, src_imm} = '1;
                end
                OP_STORE: if (funct3 == F3_WORD) begin
                    {use_rs1, use_rs2, is_store, src_imm} = '1;
                    imm = imm_s;
                end
                OP_BRANCH: if (funct3 == F3_BEQ || funct3 == F3_BNE) begin
                    {use_rs1, use_rs2, is_branch} = '1;
                    branch_ne = (funct3 == F3_BNE);
                    imm       = imm_b;
                end
                OP_JAL: begin
                    {is_jal, reg_we} = '1;
                    imm = imm_j;
                end
                default: ;                              // outside the subset, no effect
            endcase
        end
    end

    // unused source fields read as x0 so they never stall or forward
    assign id_rs1 = use_rs1 ? id_instr[19:15] : '0;
    assign id_rs2 = use_rs2 ? id_instr[24:20] : '0;

    // write-through read ports
    assign rs1_data = (id_rs1 == '0) ? '0 :
                      (wb_reg_we && wb_rd == id_rs1) ? wb_data : regs[id_rs1];
    assign rs2_data = (id_rs2 == '0) ? '0 :
                      (wb_reg_we && wb_rd == id_rs2) ? wb_data : regs[id_rs2];

    always_ff @(posedge clk) begin
        if (!hold && wb_reg_we && wb_rd != '0)
            regs[wb_rd] <= wb_data;
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            {ex_is_load, ex_is_store, ex_is_branch, ex_is_jal, ex_reg_we} <= '0;
        end else if (!hold) begin
            if (id_ex_flush)
                {ex_is_load, ex_is_store, ex_is_branch, ex_is_jal, ex_reg_we} <= '0;
            else
                {ex_is_load, ex_is_store, ex_is_branch, ex_is_jal, ex_reg_we} <=
                    {is_load, is_store, is_branch, is_jal, reg_we};
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            ex_pc          <= id_pc;
            ex_rs1_data    <= rs1_data;
            ex_rs2_data    <= rs2_data;
            ex_imm         <= imm;
            ex_rd          <= id_instr[11:7];
            ex_rs1         <= id_rs1;
            ex_rs2         <= id_rs2;
            ex_alu_op      <= alu_op;
            ex_alu_src_imm <= src_imm;
            ex_branch_ne   <= branch_ne;
        end
    end

endmodule

/* design/execute_stage.sv */
module execute_stage
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      hold,
    input  word_t     ex_pc,
    input  word_t     ex_rs1_data,
    input  word_t     ex_rs2_data,
    input  word_t     ex_imm,
    input  reg_addr_t ex_rd,
    input  alu_op_t   ex_alu_op,
    input  logic      ex_alu_src_imm,
    input  logic      ex_is_load,
    input  logic      ex_is_store,
    input  logic      ex_is_branch,
    input  logic      ex_branch_ne,
    input  logic      ex_is_jal,
    input  logic      ex_reg_we,
    input  fwd_sel_t  fwd_mem,
    input  fwd_sel_t  fwd_wb,
    input  word_t     wb_data,
    output logic      ex_redirect,
    output word_t     redirect_pc,
    output word_t     mem_alu_result,
    output word_t     mem_store_data,
    output reg_addr_t mem_rd,
    output logic      mem_reg_we,
    output logic      mem_is_load,
    output logic      mem_is_store
);

    word_t rs1_val, rs2_val;
    word_t op_b;
    word_t alu_out;
    word_t result;
    logic  equal;

    // MEM result first, it is the younger write
    assign rs1_val = fwd_mem[FWD_RS1] ? mem_alu_result :
                     fwd_wb[FWD_RS1]  ? wb_data : ex_rs1_data;
    assign rs2_val = fwd_mem[FWD_RS2] ? mem_alu_result :
                     fwd_wb[FWD_RS2]  ? wb_data : ex_rs2_data;

    assign op_b = ex_alu_src_imm ? ex_imm : rs2_val;

    always_comb begin
        case (ex_alu_op)
            ALU_ADD:   alu_out = rs1_val + op_b;
            ALU_SUB:   alu_out = rs1_val - op_b;
            ALU_AND:   alu_out = rs1_val & op_b;
            ALU_OR:    alu_out = rs1_val | op_b;
            ALU_XOR:   alu_out = rs1_val ^ op_b;
            ALU_SLT:   alu_out = word_t'($signed(rs1_val) < $signed(op_b));
            ALU_PASSB: alu_out = op_b;
            default:   alu_out = rs1_val + op_b;
        endcase
    end

    // jal writes the link address instead
    assign result = ex_is_jal ? ex_pc + word_t'(4) : alu_out;

    // beq/bne compare the forwarded register values
    assign equal       = (rs1_val == rs2_val);
    assign ex_redirect = ex_is_jal || (ex_is_branch && (equal ^ ex_branch_ne));
    assign redirect_pc = ex_pc + ex_imm;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mem_reg_we   <= 1'b0;
            mem_is_load  <= 1'b0;
            mem_is_store <= 1'b0;
        end else if (!hold) begin
            mem_reg_we   <= ex_reg_we;
            mem_is_load  <= ex_is_load;
            mem_is_store <= ex_is_store;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            mem_alu_result <= result;
            mem_store_data <= rs2_val;
            mem_rd         <= ex_rd;
        end
    end

endmodule

/* design/memory_stage.sv */
module memory_stage
    import rv_isa_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      hold,
    input  word_t     mem_alu_result,
    input  word_t     mem_store_data,
    input  reg_addr_t mem_rd,
    input  logic      mem_reg_we,
    input  logic      mem_is_load,
    input  logic      mem_is_store,
    input  word_t     dmem_rdata,
    output word_t     dmem_addr,
    output word_t     dmem_wdata,
    output logic      dmem_we,
    output logic      dmem_re,
    output reg_addr_t wb_rd,
    output logic      wb_reg_we,
    output word_t     wb_data
);

    word_t result;

    assign dmem_addr  = mem_alu_result;
    assign dmem_wdata = mem_store_data;
    assign dmem_we    = mem_is_store && !hold;  // one strobe per store
    assign dmem_re    = mem_is_load && !hold;

    // write-back select, before the MEM/WB register
    assign result = mem_is_load ? dmem_rdata : mem_alu_result;

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            wb_reg_we <= 1'b0;
        else if (!hold)
            wb_reg_we <= mem_reg_we;
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            wb_rd   <= mem_rd;
            wb_data <= result;
        end
    end

endmodule

/* design/hazard_unit.sv */
module hazard_unit
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  reg_addr_t id_rs1,
    input  reg_addr_t id_rs2,
    input  reg_addr_t ex_rd,
    input  reg_addr_t ex_rs1,
    input  reg_addr_t ex_rs2,
    input  reg_addr_t mem_rd,
    input  reg_addr_t wb_rd,
    input  logic      ex_is_load,
    input  logic      mem_reg_we,
    input  logic      wb_reg_we,
    input  logic      ex_redirect,
    output fwd_sel_t  fwd_mem,
    output fwd_sel_t  fwd_wb,
    output logic      pc_stall,
    output logic      if_id_stall,
    output logic      if_id_flush,
    output logic      id_ex_flush
);

    logic load_use;
    logic mem_hit_rs1, mem_hit_rs2;
    logic wb_hit_rs1, wb_hit_rs2;

    // load result not ready until it reaches WB
    assign load_use = ex_is_load && (ex_rd != '0) &&
                      ((ex_rd == id_rs1) || (ex_rd == id_rs2));

    assign mem_hit_rs1 = mem_reg_we && (mem_rd != '0) && (mem_rd == ex_rs1);
    assign mem_hit_rs2 = mem_reg_we && (mem_rd != '0) && (mem_rd == ex_rs2);
    assign wb_hit_rs1  = wb_reg_we && (wb_rd != '0) && (wb_rd == ex_rs1);
    assign wb_hit_rs2  = wb_reg_we && (wb_rd != '0) && (wb_rd == ex_rs2);

    always_comb begin
        fwd_mem     = '0;
        fwd_wb      = '0;
        pc_stall    = 1'b0;
        if_id_stall = 1'b0;
        if_id_flush = 1'b0;
        id_ex_flush = 1'b0;

        fwd_mem[FWD_RS1] = mem_hit_rs1;
        fwd_mem[FWD_RS2] = mem_hit_rs2;
        fwd_wb[FWD_RS1]  = wb_hit_rs1 && !mem_hit_rs1;
        fwd_wb[FWD_RS2]  = wb_hit_rs2 && !mem_hit_rs2;

        if (ex_redirect) begin
            if_id_flush = 1'b1;             // kill both shadow slots
            id_ex_flush = 1'b1;
        end else if (load_use) begin
            pc_stall    = 1'b1;
            if_id_stall = 1'b1;
            id_ex_flush = 1'b1;             // bubble into EX
        end
    end

endmodule

/* design/rv_pipe_top.sv */
module rv_pipe_top
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  hold,
    input  word_t imem_data,
    input  word_t dmem_rdata,
    output word_t imem_addr,
    output word_t dmem_addr,
    output word_t dmem_wdata,
    output logic  dmem_we,
    output logic  dmem_re
);

    // hazard control
    logic      pc_stall, if_id_stall, if_id_flush, id_ex_flush;
    fwd_sel_t  fwd_mem, fwd_wb;

    word_t     id_pc, id_instr;
    logic      id_valid;
    reg_addr_t id_rs1, id_rs2;

    // ID/EX
    word_t     ex_pc, ex_rs1_data, ex_rs2_data, ex_imm;
    reg_addr_t ex_rd, ex_rs1, ex_rs2;
    alu_op_t   ex_alu_op;
    logic      ex_alu_src_imm, ex_is_load, ex_is_store, ex_is_branch;
    logic      ex_branch_ne, ex_is_jal, ex_reg_we;
    logic      ex_redirect;
    word_t     redirect_pc;

    // EX/MEM and MEM/WB
    word_t     mem_alu_result, mem_store_data;
    reg_addr_t mem_rd, wb_rd;
    logic      mem_reg_we, mem_is_load, mem_is_store, wb_reg_we;
    word_t     wb_data;

    fetch_stage u_fetch (.*);

    decode_stage u_decode (.*);

    execute_stage u_execute (.*);

    memory_stage u_memory (.*);

    hazard_unit u_hazard (.*);

endmodule

/* test/rv_pipe_props.sv */
module rv_pipe_props
    import rv_isa_pkg::*;
    import rv_ctrl_pkg::*;
(
    input logic      clk,
    input logic      reset,
    input logic      ex_is_load,
    input reg_addr_t ex_rs1,
    input reg_addr_t ex_rs2,
    input logic      pc_stall,
    input logic      if_id_stall,
    input logic      id_ex_flush,
    input fwd_sel_t  fwd_mem,
    input fwd_sel_t  fwd_wb
);

    timeunit 1ns;
    timeprecision 100ps;

    int fails = 0;

    // a stall only for a load in EX, always with a bubble behind it
    a_stall_bubble: assert property (@(posedge clk) disable iff (reset)
        pc_stall |-> (if_id_stall && id_ex_flush && ex_is_load))
        else begin
            $error("load-use stall without ID/EX bubble");
            fails++;
        end

    a_fwd_exclusive: assert property (@(posedge clk) disable iff (reset)
        (fwd_mem & fwd_wb) == 2'b00)
        else begin
            $error("MEM and WB forward select the same operand");
            fails++;
        end

    a_no_x0_rs1: assert property (@(posedge clk) disable iff (reset)
        (fwd_mem[FWD_RS1] || fwd_wb[FWD_RS1]) |-> (ex_rs1 != '0))
        else begin
            $error("forward selected for rs1 = x0");
            fails++;
        end

    a_no_x0_rs2: assert property (@(posedge clk) disable iff (reset)
        (fwd_mem[FWD_RS2] || fwd_wb[FWD_RS2]) |-> (ex_rs2 != '0))
        else begin
            $error("forward selected for rs2 = x0");
            fails++;
        end

endmodule

// hazard unit signals, sampled on the pipeline clock of the top level
bind rv_pipe_top rv_pipe_props u_props (.*);

/* test/rv_pipe_tb.sv */
`include "rv_pipe_cfg.svh"

module rv_pipe_tb
    import rv_isa_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_NS      = 40;
    localparam int N_PROGS     = 4;
    localparam int PROG_WORDS  = 128;
    localparam int DMEM_WORDS  = 128;
    localparam int WATCHDOG_NS = 40 * PROG_WORDS * N_PROGS * 2 * CLK_NS;  // each program runs twice
    localparam word_t HALT     = 32'h0000_006f;                            // jal x0, 0

    logic  clk, reset, hold;
    word_t imem_data, dmem_rdata, imem_addr, dmem_addr, dmem_wdata;
    logic  dmem_we, dmem_re;

    word_t imem [PROG_WORDS];
    word_t dmem [DMEM_WORDS];
    word_t exp_addr [$];
    word_t exp_data [$];
    int    exp_idx, pos, since_reset;
    int    checked, mismatches, failures;
    bit    hold_mode;

    rv_pipe_top UUT (.*);

    assign imem_data  = imem[imem_addr[8:2]];
    assign dmem_rdata = dmem[dmem_addr[8:2]];     // combinational read

    always @(posedge clk) begin
        if (dmem_we)
            dmem[dmem_addr[8:2]] <= dmem_wdata;
    end

    function automatic word_t fill_word(word_t addr);
        return (addr * 32'h9e37_79b1) ^ {addr[15:0], addr[31:16]};
    endfunction

    function automatic word_t enc_r(funct3_t f3, logic sub, int rd, int rs1, int rs2);
        return {sub ? F7_SUB : 7'b0, 5'(rs2), 5'(rs1), f3, 5'(rd), OP_REG};
    endfunction

    function automatic word_t enc_i(opcode_t op, funct3_t f3, int rd, int rs1, logic [11:0] imm);
        return {imm, 5'(rs1), f3, 5'(rd), op};
    endfunction

    // sw rs2, off(x0)
    function automatic word_t enc_sw(int rs2, logic [11:0] off);
        return {off[11:5], 5'(rs2), 5'd0, F3_WORD, off[4:0], OP_STORE};
    endfunction

    function automatic word_t enc_b(funct3_t f3, int rs1, int rs2, logic [12:0] off);
        return {off[12], off[10:5], 5'(rs2), 5'(rs1), f3, off[4:1], off[11], OP_BRANCH};
    endfunction

    function automatic word_t enc_jal(int rd, logic [20:0] off);
        return {off[20], off[10:1], off[11], off[19:12], 5'(rd), OP_JAL};
    endfunction

    function automatic funct3_t pick_f3();
        case ($urandom_range(4))
            0:       return F3_ADD;
            1:       return F3_SLT;
            2:       return F3_XOR;
            3:       return F3_OR;
            default: return F3_AND;
        endcase
    endfunction

    // words 0..63 for real data, 64..127 only for shadow-slot stores
    function automatic logic [11:0] data_off();
        return {4'd0, 6'($urandom_range(63)), 2'b00};
    endfunction

    function automatic logic [11:0] shadow_off();
        return {3'd0, 1'b1, 6'($urandom_range(63)), 2'b00};
    endfunction

    function automatic word_t arith(funct3_t f3, logic sub, word_t a, word_t b);
        case (f3)
            F3_ADD:  return sub ? a - b : a + b;
            F3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            F3_XOR:  return a ^ b;
            F3_OR:   return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic emit(word_t instr);
        imem[pos[6:0]] = instr;
        pos++;
    endtask

    task automatic build_program();
        int      rd, rs1, rs2;
        funct3_t f3;
        pos = 0;
        for (int r = 1; r < 8; r++)
            emit(enc_i(OP_IMM, F3_ADD, r, 0, 12'($urandom)));  // reset leaves x1..x7 as they were
        while (pos < PROG_WORDS - 8) begin
            rd  = $urandom_range(7);    // few registers for many dependences
            rs1 = $urandom_range(7);
            rs2 = $urandom_range(7);
            f3  = pick_f3();
            case ($urandom_range(5))
                0: emit(enc_r(f3, f3 == F3_ADD && $urandom_range(1) == 1, rd, rs1, rs2));
                1: emit(enc_i(OP_IMM, f3, rd, rs1, 12'($urandom)));
                2: emit({20'($urandom), 5'(rd), OP_LUI});
                3: begin                                        // load, then use at once
                    emit(enc_i(OP_LOAD, F3_WORD, rd, 0, data_off()));
                    emit(enc_r(f3, 1'b0, rd, rd, rs2));
                end
                4: begin
                    emit(enc_b($urandom_range(1) == 1 ? F3_BNE : F3_BEQ, rs1, rs2, 13'd12));
                    emit(enc_sw(rs1, shadow_off()));
                    emit(enc_sw(rs2, shadow_off()));
                end
                default: begin
                    emit(enc_jal(rd, 21'd12));                  // link stored below
                    emit(enc_sw(rd, shadow_off()));
                    emit(enc_sw(rs1, shadow_off()));
                end
            endcase
            if ($urandom_range(1) == 1)
                emit(enc_i(OP_IMM, F3_XOR, 0, rd, 12'($urandom)));  // x0 write between producer and store
            emit(enc_sw(rd, data_off()));
        end
        while (pos < PROG_WORDS)
            emit(HALT);
    endtask

    // architectural run of the program one instruction per step
    function automatic void run_reference();
        word_t x [`RV_REGS];
        word_t ram [DMEM_WORDS];
        word_t pc, next, ins, a, b, addr, imm_b, imm_j;
        exp_addr.delete();
        exp_data.delete();
        foreach (x[i])
            x[i] = '0;
        foreach (ram[i])
            ram[i] = fill_word(word_t'(i * 4));
        pc = `RV_RESET_PC;
        for (int step = 0; step < 4 * PROG_WORDS; step++) begin
            ins   = imem[pc[8:2]];
            a     = x[ins[19:15]];
            b     = x[ins[24:20]];
            imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
            imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
            next  = pc + 32'd4;
            if (ins == HALT)
                break;
            case (ins[6:0])
                OP_REG: x[ins[11:7]] = arith(ins[14:12], ins[30], a, b);
                OP_IMM: x[ins[11:7]] = arith(ins[14:12], 1'b0, a, {{20{ins[31]}}, ins[31:20]});
                OP_LUI: x[ins[11:7]] = {ins[31:12], 12'b0};
                OP_LOAD: begin
                    addr         = a + {{20{ins[31]}}, ins[31:20]};
                    x[ins[11:7]] = ram[addr[8:2]];
                end
                OP_STORE: begin
                    addr           = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
                    ram[addr[8:2]] = b;
                    exp_addr.push_back(addr);
                    exp_data.push_back(b);
                end
                OP_BRANCH: begin
                    if ((a == b) != (ins[14:12] == F3_BNE))
                        next = pc + imm_b;
                end
                OP_JAL: begin
                    x[ins[11:7]] = pc + 32'd4;
                    next         = pc + imm_j;
                end
                default: ;
            endcase
            x[0] = '0;
            pc   = next;
        end
    endfunction

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // store comparator
    always @(posedge clk) begin
        if (reset) begin
            since_reset = 0;
        end else begin
            since_reset++;
            if (since_reset <= 3 && (dmem_we || dmem_re)) begin
                failures++;
                $display("%0t ns: data memory strobe only %0d cycles after reset",
                         $time, since_reset);
            end
            if (dmem_we) begin
                if (exp_idx >= exp_addr.size()) begin
                    failures++;
                    $display("%0t ns: store to %h arrived after the expected list ended",
                             $time, dmem_addr);
                end else begin
                    checked++;
                    if (dmem_addr !== exp_addr[exp_idx]) begin
                        mismatches++;
                        $display("ERROR %0t ns dmem_addr: got %h, expected %h",
                                 $time, dmem_addr, exp_addr[exp_idx]);
                    end
                    if (dmem_wdata !== exp_data[exp_idx]) begin
                        mismatches++;
                        $display("ERROR %0t ns dmem_wdata: got %h, expected %h",
                                 $time, dmem_wdata, exp_data[exp_idx]);
                    end
                    exp_idx++;
                end
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired after %0d ns, %0d of %0d stores of the current run seen",
                 WATCHDOG_NS, exp_idx, exp_addr.size());
        $display("RESULT: FAIL");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        hold        = 1'b0;
        hold_mode   = 1'b0;
        exp_idx     = 0;
        since_reset = 0;
        checked     = 0;
        mismatches  = 0;
        failures    = 0;
        void'($urandom(24));
        for (int run = 0; run < 2 * N_PROGS; run++) begin
            hold_mode = (run % 2) == 1;     // odd runs repeat the program with hold pulses
            reset     = 1'b1;
            if (!hold_mode) begin
                build_program();
                run_reference();
            end
            foreach (dmem[i])
                dmem[i] = fill_word(word_t'(i * 4));
            exp_idx = 0;
            repeat (2) @(negedge clk);
            if (imem_addr !== `RV_RESET_PC || dmem_we !== 1'b0 || dmem_re !== 1'b0) begin
                failures++;
                $display("%0t ns: in reset the fetch address is %h or a memory strobe is high",
                         $time, imem_addr);
            end
            reset = 1'b0;
            while (exp_idx < exp_addr.size()) begin
                @(negedge clk);
                hold = hold_mode && ($urandom_range(3) == 0);
            end
            hold = 1'b0;
            repeat (8) @(negedge clk);      // stray stores past the list show up here
        end
        $display("stores checked %0d, value errors %0d, other errors %0d, assertion failures %0d",
                 checked, mismatches, failures, UUT.u_props.fails);
        if (mismatches == 0 && failures == 0 && UUT.u_props.fails == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* rv_pipe.f */
+incdir+common
common/rv_isa_pkg.sv
common/rv_ctrl_pkg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/memory_stage.sv
design/hazard_unit.sv
design/rv_pipe_top.sv
test/rv_pipe_props.sv
test/rv_pipe_tb.sv

/* Makefile */
# Verilator build and run of the rv_pipe testbench

TOP := rv_pipe_tb
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run, then search the log for the pass line"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   this list"

test:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f rv_pipe.f -o $(TOP)
	./obj_dir/$(TOP) +verilator+error+limit+1000 | tee $(LOG)
	@grep -q "RESULT: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
